/* spu_params.svh */
/*
 * shift unit parameters
 * datapath widths shared by the package, the pipeline stages and the testbench
 */
`ifndef SPU_PARAMS_SVH
`define SPU_PARAMS_SVH

// ----------------------------------------
// datapath widths
// ----------------------------------------

// operand and result width
`define SPU_DATA_W 32

// register shift amount, low byte of the shift register
`define SPU_AMT_W 8

// immediate shift amount field of the instruction
`define SPU_IMM_W 5

// byte lanes in the permute crossbar
`define SPU_LANES 4

`endif

/* spu_pkg.sv */
/*
 * shift unit package
 * opcode and amount-source enums plus the request, decode,
 * stage and result structs passed along the two-stage pipeline
 */
`default_nettype none
`include "spu_params.svh"

package spu_pkg;

   // ----------------------------------------
   // encodings
   // ----------------------------------------

   typedef enum logic [1:0] {
      OP_LSL = 2'd0,
      OP_LSR = 2'd1,
      OP_ASR = 2'd2,
      OP_ROR = 2'd3
   } shift_op_e;

   // shift amount taken from the instruction or from a register
   typedef enum logic {
      SRC_IMM = 1'b0,
      SRC_REG = 1'b1
   } amt_src_e;

   // ----------------------------------------
   // pipeline payloads
   // ----------------------------------------

   typedef struct packed {
      shift_op_e               op;
      amt_src_e                src;
      logic [`SPU_IMM_W-1:0]   imm;
      logic [`SPU_AMT_W-1:0]   reg_amt;
      logic [`SPU_DATA_W-1:0]  operand;
      logic                    cflag;    // incoming carry
   } spu_req_t;

   // normalised request, held in the decode register
   typedef struct packed {
      shift_op_e               op;
      logic [`SPU_DATA_W-1:0]  operand;
      logic                    cflag;
      logic [`SPU_AMT_W-1:0]   rot_amt;     // full amount, drives the >32 cases
      logic [`SPU_IMM_W-1:0]   ror_amt;     // right rotate equivalent, mod 32
      logic                    shift_left;
      logic                    zero_shift;  // ror_amt is zero
      logic                    ge_32;       // shift clears every lane
   } spu_dec_t;

   // rotator output, lane selects indexed [dest byte][source lane]
   typedef struct packed {
      logic [`SPU_DATA_W-1:0]               rot_out;
      logic                                 rot_sign;
      logic [`SPU_LANES-1:0][`SPU_LANES-1:0] lane_sel;
      logic [`SPU_LANES-1:0]                lane_sgn;
      logic                                 carry;
   } spu_stage_t;

   typedef struct packed {
      logic [`SPU_DATA_W-1:0]  res;
      logic                    nflag;
      logic                    zflag;
      logic                    cflag;
   } spu_res_t;

endpackage

`default_nettype wire

/* spu_amount_decode.sv */
/*
 * shift unit amount decode
 * first pipeline stage, normalises the shift amount of each request
 * into a right-rotate amount plus the zero and >=32 indicators
 */
`default_nettype none
`include "spu_params.svh"

module spu_amount_decode (
   input  logic              hclk_i,
   input  logic              arst_n_i,
   input  logic              req_valid_i,
   input  spu_pkg::spu_req_t req_i,
   output logic              dec_valid_o,
   output spu_pkg::spu_dec_t dec_o
);

   logic                  imm_zero;
   logic                  imm_is_32;
   logic [`SPU_AMT_W-1:0] imm_amt;
   logic [`SPU_AMT_W-1:0] rot_amt;
   logic [`SPU_IMM_W-1:0] rol_amt;
   logic [`SPU_IMM_W-1:0] ror_amt;
   logic                  shift_left;
   logic                  is_ror;
   spu_pkg::spu_dec_t     dec_d;

   // ----------------------------------------
   // amount normalisation
   // ----------------------------------------

   // immediate zero is "no shift" for lsl but 32 for lsr and asr
   assign imm_zero  = ~|req_i.imm;
   assign imm_is_32 = imm_zero &
                      ((req_i.op == spu_pkg::OP_LSR) | (req_i.op == spu_pkg::OP_ASR));

   // 32 is bit 5 alone, so the immediate field is cleared under it
   assign imm_amt = {{(`SPU_AMT_W - `SPU_IMM_W - 1){1'b0}},
                     imm_is_32,
                     {`SPU_IMM_W{~imm_is_32}} & req_i.imm};

   // register amounts use the whole low byte
   assign rot_amt = (req_i.src == spu_pkg::SRC_REG) ? req_i.reg_amt : imm_amt;

   // ----------------------------------------
   // rotate-right equivalent
   // ----------------------------------------

   // the rotator only turns right, lsl by n is ror by 32-n
   assign shift_left = (req_i.op == spu_pkg::OP_LSL);
   assign is_ror     = (req_i.op == spu_pkg::OP_ROR);
   assign rol_amt    = '0 - rot_amt[`SPU_IMM_W-1:0];
   assign ror_amt    = shift_left ? rol_amt : rot_amt[`SPU_IMM_W-1:0];

   always_comb begin
      dec_d.op         = req_i.op;
      dec_d.operand    = req_i.operand;
      dec_d.cflag      = req_i.cflag;
      dec_d.rot_amt    = rot_amt;
      dec_d.ror_amt    = ror_amt;
      dec_d.shift_left = shift_left;
      dec_d.zero_shift = ~|ror_amt;
      // ror wraps around, every other op empties the word at 32 and up
      dec_d.ge_32      = (|rot_amt[`SPU_AMT_W-1:`SPU_IMM_W]) & ~is_ror;
   end

   // ----------------------------------------
   // decode register
   // ----------------------------------------

   always_ff @(posedge hclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         dec_valid_o <= 1'b0;
         dec_o       <= '0;
      end else begin
         dec_valid_o <= req_valid_i;
         // payload only moves on a strobe
         if (req_valid_i) begin
            dec_o <= dec_d;
         end
      end
   end

   // ror by immediate is not an encodable request
   a_no_ror_imm: assert property (@(posedge hclk_i) disable iff (!arst_n_i)
      req_valid_i |-> !((req_i.op == spu_pkg::OP_ROR) && (req_i.src == spu_pkg::SRC_IMM)))
      else $error("spu_amount_decode: ror with immediate amount requested");

endmodule

`default_nettype wire

/* spu_rotator.sv */
/*
 * shift unit rotator
 * second pipeline stage, 0-7 bit rotate with top byte masking and
 * sign insertion, lane select generation and carry, registered
 */
`default_nettype none
`include "spu_params.svh"

module spu_rotator (
   input  logic                hclk_i,
   input  logic                arst_n_i,
   input  logic                dec_valid_i,
   input  spu_pkg::spu_dec_t   dec_i,
   output logic                stg_valid_o,
   output spu_pkg::spu_stage_t stg_o
);

   localparam int DW    = `SPU_DATA_W;
   localparam int LANES = `SPU_LANES;
   localparam int LW    = `SPU_DATA_W / `SPU_LANES;

   logic                        is_ror;
   logic                        is_asr;
   logic                        keep_wrap;
   logic [1:0]                  ror_byte;
   logic [2:0]                  ror_bit;
   logic [DW-1:0]               ror_in;
   logic [DW-1:0]               ror_val_0;
   logic [DW-1:0]               ror_val;
   logic [LW-1:0]               top_base;
   logic [LW-1:0]               top_keep;
   logic                        rot_sign;
   logic [DW-1:0]               rot_out;
   logic [DW-1:0]               full_rot;
   logic [LANES-1:0][LANES-1:0] lane_sel;
   logic [LANES-1:0]            lane_sgn;
   logic                        rot_eq_00;
   logic                        rot_gt_32;
   logic                        c_gt_32;
   logic                        c_le_32;
   spu_pkg::spu_stage_t         stg_d;

   assign is_ror    = (dec_i.op == spu_pkg::OP_ROR);
   assign is_asr    = (dec_i.op == spu_pkg::OP_ASR);
   // ror and lsl may bring lanes round the top of the word
   assign keep_wrap = is_ror | dec_i.shift_left;
   assign ror_byte  = dec_i.ror_amt[4:3];
   assign ror_bit   = dec_i.ror_amt[2:0];
   assign ror_in    = dec_i.operand;

   // ----------------------------------------
   // 0-7 bit rotate right
   // ----------------------------------------

   always_comb begin
      case (ror_bit[1:0])
         2'd0:    ror_val_0 = ror_in;
         2'd1:    ror_val_0 = {ror_in[0],   ror_in[DW-1:1]};
         2'd2:    ror_val_0 = {ror_in[1:0], ror_in[DW-1:2]};
         default: ror_val_0 = {ror_in[2:0], ror_in[DW-1:3]};
      endcase
   end

   assign ror_val = ror_bit[2] ? {ror_val_0[3:0], ror_val_0[DW-1:4]} : ror_val_0;

   // ----------------------------------------
   // top byte mask and sign
   // ----------------------------------------

   // wrapped bits sit in the top byte only, right shifts drop the
   // upper ror_bit bits there, left shifts keep just those
   assign top_base = {LW{1'b1}} >> ror_bit;
   assign top_keep = (top_base ^ {LW{dec_i.shift_left & ~dec_i.zero_shift}}) |
                     {LW{is_ror}};

   // asr refills dropped bits with the operand sign
   assign rot_sign = is_asr & ror_in[DW-1];
   assign rot_out  = {(ror_val[DW-1 -: LW] & top_keep) | ({LW{rot_sign}} & ~top_keep),
                      ror_val[DW-LW-1:0]};

   // ----------------------------------------
   // crossbar selects
   // ----------------------------------------

   always_comb begin
      for (int b = 0; b < LANES; b++) begin
         for (int j = 0; j < LANES; j++) begin
            // byte b takes lane b+ror_byte, wrapped lanes only for ror and lsl,
            // a left shift also empties the bytes under the shift amount
            lane_sel[b][j] = ((2'(b) + ror_byte) == 2'(j)) &
                             ((j >= b) | keep_wrap) &
                             (~dec_i.shift_left | dec_i.zero_shift |
                              (ror_byte >= 2'(LANES - 1 - b))) &
                             ~dec_i.ge_32;
         end
         // an empty byte gets the sign instead
         lane_sgn[b] = ~|lane_sel[b];
      end
   end

   // ----------------------------------------
   // carry
   // ----------------------------------------

   // whole-word rotation, bit 0 is the last bit out of a left shift
   // and bit 31 the last out of a right shift
   always_comb begin
      case (ror_byte)
         2'd0:    full_rot = ror_val;
         2'd1:    full_rot = {ror_val[LW-1:0],   ror_val[DW-1:LW]};
         2'd2:    full_rot = {ror_val[2*LW-1:0], ror_val[DW-1:2*LW]};
         default: full_rot = {ror_val[3*LW-1:0], ror_val[DW-1:3*LW]};
      endcase
   end

   assign rot_eq_00 = ~|dec_i.rot_amt;
   assign rot_gt_32 = (|dec_i.rot_amt[`SPU_AMT_W-1:6]) |
                      (dec_i.rot_amt[5] & |dec_i.rot_amt[4:0]);

   // past 32, lsl and lsr give 0, asr the sign, ror keeps bit 31
   assign c_gt_32 = (is_ror & full_rot[DW-1]) | (is_asr & rot_sign);
   assign c_le_32 = dec_i.shift_left ? full_rot[0] : full_rot[DW-1];

   always_comb begin
      stg_d.rot_out  = rot_out;
      stg_d.rot_sign = rot_sign;
      stg_d.lane_sel = lane_sel;
      stg_d.lane_sgn = lane_sgn;
      // zero amount leaves c alone
      stg_d.carry    = rot_eq_00 ? dec_i.cflag : (rot_gt_32 ? c_gt_32 : c_le_32);
   end

   // ----------------------------------------
   // stage register
   // ----------------------------------------

   always_ff @(posedge hclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         stg_valid_o <= 1'b0;
         stg_o       <= '0;
      end else begin
         stg_valid_o <= dec_valid_i;
         if (dec_valid_i) begin
            stg_o <= stg_d;
         end
      end
   end

   // each output byte draws on at most one source lane
   a_sel_onehot0: assert property (@(posedge hclk_i) disable iff (!arst_n_i)
      stg_valid_o |-> ($onehot0(stg_o.lane_sel[0]) && $onehot0(stg_o.lane_sel[1]) &&
                       $onehot0(stg_o.lane_sel[2]) && $onehot0(stg_o.lane_sel[3])))
      else $error("spu_rotator: lane select not one-hot");

endmodule

`default_nettype wire

/* spu_lane_matrix.sv */
/*
 * shift unit lane matrix
 * 4x4 byte-lane crossbar with sign injection, N and Z predicted
 * from the lane selects, combinational from the stage register
 */
`default_nettype none
`include "spu_params.svh"

module spu_lane_matrix (
   input  logic                stg_valid_i,
   input  spu_pkg::spu_stage_t stg_i,
   output logic                res_valid_o,
   output spu_pkg::spu_res_t   res_o
);

   localparam int LANES = `SPU_LANES;
   localparam int LW    = `SPU_DATA_W / `SPU_LANES;

   logic [`SPU_DATA_W-1:0] res;
   logic [LANES-1:0]       sgn_fill;
   logic [LANES-1:0]       lane_used;
   logic [LANES-1:0]       lane_set;
   logic                   nflag;
   logic                   zflag;

   // ----------------------------------------
   // crossbar and flags
   // ----------------------------------------

   always_comb begin
      res       = '0;
      lane_used = '0;
      nflag     = 1'b0;

      // sign goes only into bytes left empty by the selects
      sgn_fill = stg_i.lane_sgn & {LANES{stg_i.rot_sign}};

      for (int b = 0; b < LANES; b++) begin
         for (int j = 0; j < LANES; j++) begin
            res[b*LW +: LW] = res[b*LW +: LW] |
                              ({LW{stg_i.lane_sel[b][j]}} & stg_i.rot_out[j*LW +: LW]);
         end
         res[b*LW +: LW] = res[b*LW +: LW] | {LW{sgn_fill[b]}};
         // lanes that reach the result at all
         lane_used = lane_used | stg_i.lane_sel[b];
      end

      // non-zero test per source lane
      for (int j = 0; j < LANES; j++) begin
         lane_set[j] = |stg_i.rot_out[j*LW +: LW];
      end

      // n is the msb of whichever lane lands in the top byte
      for (int j = 0; j < LANES; j++) begin
         nflag = nflag | (stg_i.lane_sel[LANES-1][j] & stg_i.rot_out[j*LW + LW - 1]);
      end
      nflag = nflag | sgn_fill[LANES-1];

      // zero when no used lane has a set bit and no sign is injected,
      // no need to wait for the crossbar output
      zflag = ~((|(lane_set & lane_used)) | (|sgn_fill));

      // prediction must agree with the assembled word
      if (stg_valid_i) begin
         a_zflag_match: assert (zflag == (res == '0))
            else $error("spu_lane_matrix: zflag %0b for res %08h", zflag, res);
      end
   end

   // ----------------------------------------
   // outputs
   // ----------------------------------------

   assign res_valid_o = stg_valid_i;

   // c was settled in the rotator
   assign res_o = '{res: res, nflag: nflag, zflag: zflag, cflag: stg_i.carry};

endmodule

`default_nettype wire

/* spu.sv */
/*
 * shift unit top level
 * lsl, lsr, asr and ror on a 32-bit operand in a two-stage pipeline,
 * amount decode, rotator with stage register, then the lane matrix
 */
`default_nettype none

module spu (
   input  logic              hclk_i,
   input  logic              arst_n_i,
   input  logic              req_valid_i,
   input  spu_pkg::spu_req_t req_i,
   output logic              res_valid_o,
   output spu_pkg::spu_res_t res_o
);

   // decode register outputs
   logic                dec_valid;
   spu_pkg::spu_dec_t   dec;

   // stage register outputs
   logic                stg_valid;
   spu_pkg::spu_stage_t stg;

   // ----------------------------------------
   // stage 1, amount decode
   // ----------------------------------------

   spu_amount_decode u_decode (
      .hclk_i      (hclk_i),
      .arst_n_i    (arst_n_i),
      .req_valid_i (req_valid_i),
      .req_i       (req_i),
      .dec_valid_o (dec_valid),
      .dec_o       (dec)
   );

   // ----------------------------------------
   // stage 2, rotate and buffer
   // ----------------------------------------

   spu_rotator u_rotator (
      .hclk_i      (hclk_i),
      .arst_n_i    (arst_n_i),
      .dec_valid_i (dec_valid),
      .dec_i       (dec),
      .stg_valid_o (stg_valid),
      .stg_o       (stg)
   );

   // result is combinational off the stage register
   spu_lane_matrix u_matrix (
      .stg_valid_i (stg_valid),
      .stg_i       (stg),
      .res_valid_o (res_valid_o),
      .res_o       (res_o)
   );

endmodule

`default_nettype wire

/* tb_spu.sv */
/*
 * shift unit testbench
 * directed table and LFSR random requests against a reference model,
 * checks res, N, Z, C and the valid timing of the two-stage pipeline
 */
`default_nettype none
`include "spu_params.svh"

module tb_spu;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int DW      = `SPU_DATA_W;
   localparam int NVEC    = 27;
   localparam int NRAND   = 200;
   localparam int TIMEOUT = 10;
   localparam bit IMM     = 1'b0;
   localparam bit REG     = 1'b1;

   // one table entry, request plus expected result
   typedef struct packed {
      spu_pkg::spu_req_t req;
      spu_pkg::spu_res_t want;
   } vec_t;

   logic              hclk_i;
   logic              arst_n_i;
   logic              req_valid_i;
   spu_pkg::spu_req_t req_i;
   logic              res_valid_o;
   spu_pkg::spu_res_t res_o;

   vec_t              tab [NVEC];
   spu_pkg::spu_res_t exp_q [$];
   logic [15:0]       lfsr = 16'd2;
   logic              strobe_d1;
   logic              strobe_d2;
   int                value_errs;
   int                timing_errs;
   int                timeout_errs;

   spu dut (
      .hclk_i      (hclk_i),
      .arst_n_i    (arst_n_i),
      .req_valid_i (req_valid_i),
      .req_i       (req_i),
      .res_valid_o (res_valid_o),
      .res_o       (res_o)
   );

   // 40 ns clock
   initial begin
      hclk_i = 1'b0;
      forever #20 hclk_i = ~hclk_i;
   end

   // ----------------------------------------
   // random source
   // ----------------------------------------

   // x^16 + x^15 + x^13 + x^4 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
   endfunction

   // one lfsr step per bit, msb first
   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   // ----------------------------------------
   // reference model
   // ----------------------------------------

   function automatic spu_pkg::spu_res_t ref_shift(input spu_pkg::spu_req_t r);
      int unsigned       amt;
      int unsigned       m;
      logic [DW-1:0]     x;
      logic [DW-1:0]     y;
      logic [DW-1:0]     t;
      logic              c;
      spu_pkg::spu_res_t o;
      x   = r.operand;
      amt = (r.src == spu_pkg::SRC_REG) ? int'(r.reg_amt) : int'(r.imm);
      // immediate zero means 32 for the right shifts
      if ((r.src == spu_pkg::SRC_IMM) && (amt == 0) &&
          ((r.op == spu_pkg::OP_LSR) || (r.op == spu_pkg::OP_ASR))) begin
         amt = 32;
      end
      y = x;
      c = r.cflag;
      if (amt != 0) begin
         case (r.op)
            spu_pkg::OP_LSL: begin
               // last bit out is the one that crosses bit 31
               t = x << (amt - 1);
               y = (amt < 32) ? (x << amt) : '0;
               c = (amt <= 32) ? t[DW-1] : 1'b0;
            end
            spu_pkg::OP_LSR: begin
               t = x >> (amt - 1);
               y = (amt < 32) ? (x >> amt) : '0;
               c = (amt <= 32) ? t[0] : 1'b0;
            end
            spu_pkg::OP_ASR: begin
               t = x >> (amt - 1);
               y = (amt < 32) ? DW'($signed(x) >>> amt) : {DW{x[DW-1]}};
               c = (amt < 32) ? t[0] : x[DW-1];
            end
            default: begin
               m = amt % 32;
               y = (m == 0) ? x : ((x >> m) | (x << (DW - m)));
               c = y[DW-1];
            end
         endcase
      end
      o.res   = y;
      o.nflag = y[DW-1];
      o.zflag = (y == '0);
      o.cflag = c;
      return o;
   endfunction

   // ----------------------------------------
   // directed table
   // ----------------------------------------

   function automatic vec_t vec(input spu_pkg::shift_op_e op, input bit use_reg,
                                input int amt, input logic [DW-1:0] operand,
                                input logic cin, input logic [DW-1:0] res,
                                input logic [2:0] nzc);
      vec_t v;
      v.req.op       = op;
      v.req.src      = use_reg ? spu_pkg::SRC_REG : spu_pkg::SRC_IMM;
      v.req.imm      = use_reg ? 5'd0 : amt[4:0];
      v.req.reg_amt  = use_reg ? amt[7:0] : 8'd0;
      v.req.operand  = operand;
      v.req.cflag    = cin;
      v.want.res     = res;
      v.want.nflag   = nzc[2];
      v.want.zflag   = nzc[1];
      v.want.cflag   = nzc[0];
      return v;
   endfunction

   // expected values worked out by hand, flags as n z c
   task automatic build_table();
      // lsl by immediate, zero keeps c
      tab[ 0] = vec(spu_pkg::OP_LSL, IMM,  0, 32'h8000_0001, 1'b0, 32'h8000_0001, 3'b100);
      tab[ 1] = vec(spu_pkg::OP_LSL, IMM, 31, 32'h0000_0002, 1'b0, 32'h0000_0000, 3'b011);
      tab[ 2] = vec(spu_pkg::OP_LSL, IMM,  4, 32'h1234_5678, 1'b0, 32'h2345_6780, 3'b001);
      // right shifts by immediate, zero acts as 32
      tab[ 3] = vec(spu_pkg::OP_LSR, IMM,  0, 32'h8000_0000, 1'b0, 32'h0000_0000, 3'b011);
      tab[ 4] = vec(spu_pkg::OP_ASR, IMM,  0, 32'h8000_0000, 1'b0, 32'hFFFF_FFFF, 3'b101);
      tab[ 5] = vec(spu_pkg::OP_ASR, IMM,  0, 32'h7FFF_FFFF, 1'b1, 32'h0000_0000, 3'b010);
      tab[ 6] = vec(spu_pkg::OP_ASR, IMM,  4, 32'h8000_00F0, 1'b1, 32'hF800_000F, 3'b100);
      // lsl by register
      tab[ 7] = vec(spu_pkg::OP_LSL, REG,  0, 32'h8000_0001, 1'b0, 32'h8000_0001, 3'b100);
      tab[ 8] = vec(spu_pkg::OP_LSL, REG,  8, 32'h1234_5678, 1'b1, 32'h3456_7800, 3'b000);
      tab[ 9] = vec(spu_pkg::OP_LSL, REG, 32, 32'h0000_0001, 1'b0, 32'h0000_0000, 3'b011);
      tab[10] = vec(spu_pkg::OP_LSL, REG, 33, 32'hFFFF_FFFF, 1'b1, 32'h0000_0000, 3'b010);
      tab[11] = vec(spu_pkg::OP_LSL, REG,255, 32'hFFFF_FFFF, 1'b1, 32'h0000_0000, 3'b010);
      // lsr by register
      tab[12] = vec(spu_pkg::OP_LSR, REG,  0, 32'h8000_0000, 1'b0, 32'h8000_0000, 3'b100);
      tab[13] = vec(spu_pkg::OP_LSR, REG, 16, 32'h1234_8000, 1'b0, 32'h0000_1234, 3'b001);
      tab[14] = vec(spu_pkg::OP_LSR, REG, 32, 32'h8000_0000, 1'b0, 32'h0000_0000, 3'b011);
      tab[15] = vec(spu_pkg::OP_LSR, REG, 33, 32'hFFFF_FFFF, 1'b1, 32'h0000_0000, 3'b010);
      tab[16] = vec(spu_pkg::OP_LSR, REG,255, 32'hFFFF_FFFF, 1'b1, 32'h0000_0000, 3'b010);
      // asr by register
      tab[17] = vec(spu_pkg::OP_ASR, REG,  0, 32'h8000_0000, 1'b0, 32'h8000_0000, 3'b100);
      tab[18] = vec(spu_pkg::OP_ASR, REG, 12, 32'h8765_4321, 1'b1, 32'hFFF8_7654, 3'b100);
      tab[19] = vec(spu_pkg::OP_ASR, REG, 32, 32'h8000_0000, 1'b0, 32'hFFFF_FFFF, 3'b101);
      tab[20] = vec(spu_pkg::OP_ASR, REG, 33, 32'h7FFF_FFFF, 1'b1, 32'h0000_0000, 3'b010);
      tab[21] = vec(spu_pkg::OP_ASR, REG,255, 32'h8000_0001, 1'b0, 32'hFFFF_FFFF, 3'b101);
      // ror by register, amount mod 32
      tab[22] = vec(spu_pkg::OP_ROR, REG,  0, 32'h8000_0001, 1'b0, 32'h8000_0001, 3'b100);
      tab[23] = vec(spu_pkg::OP_ROR, REG,  4, 32'h1234_5678, 1'b0, 32'h8123_4567, 3'b101);
      tab[24] = vec(spu_pkg::OP_ROR, REG, 32, 32'h8000_0001, 1'b0, 32'h8000_0001, 3'b101);
      tab[25] = vec(spu_pkg::OP_ROR, REG, 64, 32'h0000_0001, 1'b1, 32'h0000_0001, 3'b000);
      tab[26] = vec(spu_pkg::OP_ROR, REG,255, 32'h8000_0000, 1'b1, 32'h0000_0001, 3'b000);
   endtask

   // ----------------------------------------
   // drivers and waits
   // ----------------------------------------

   task automatic send(input spu_pkg::spu_req_t r, input spu_pkg::spu_res_t want);
      @(negedge hclk_i);
      req_valid_i = 1'b1;
      req_i       = r;
      exp_q.push_back(want);
   endtask

   task automatic idle();
      @(negedge hclk_i);
      req_valid_i = 1'b0;
      req_i       = '0;
   endtask

   task automatic wait_valid();
      int cnt;
      cnt = 0;
      while (res_valid_o !== 1'b1) begin
         if (cnt == TIMEOUT) begin
            timeout_errs++;
            $display("timeout waiting for res_valid_o");
            return;
         end
         @(negedge hclk_i);
         cnt++;
      end
   endtask

   task automatic wait_drain();
      int cnt;
      cnt = 0;
      while (exp_q.size() != 0) begin
         if (cnt == TIMEOUT) begin
            timeout_errs++;
            $display("timeout with %0d results still outstanding", exp_q.size());
            return;
         end
         @(negedge hclk_i);
         cnt++;
      end
   endtask

   // ror never takes an immediate
   task automatic make_random(output spu_pkg::spu_req_t r, output bit gap);
      logic [31:0] bits;
      take_bits(2, bits);
      r.op = spu_pkg::shift_op_e'(bits[1:0]);
      take_bits(1, bits);
      r.src = ((r.op == spu_pkg::OP_ROR) || bits[0]) ? spu_pkg::SRC_REG : spu_pkg::SRC_IMM;
      take_bits(5, bits);
      r.imm = bits[4:0];
      // small register amounts half the time, else the full byte
      take_bits(1, bits);
      if (bits[0]) begin
         take_bits(6, bits);
         r.reg_amt = {2'b00, bits[5:0]};
      end else begin
         take_bits(8, bits);
         r.reg_amt = bits[7:0];
      end
      take_bits(32, bits);
      r.operand = bits;
      take_bits(1, bits);
      r.cflag = bits[0];
      take_bits(1, bits);
      gap = bits[0];
   endtask

   task automatic run_tests();
      spu_pkg::spu_req_t r;
      bit                gap;
      // directed entries one at a time
      for (int i = 0; i < NVEC; i++) begin
         send(tab[i].req, tab[i].want);
         idle();
         wait_valid();
         if (timeout_errs != 0) begin
            return;
         end
      end
      // random, mostly back to back with the odd idle cycle
      for (int i = 0; i < NRAND; i++) begin
         make_random(r, gap);
         send(r, ref_shift(r));
         if (gap) begin
            idle();
         end
      end
      idle();
      wait_drain();
      // no stray valids afterwards
      repeat (3) @(negedge hclk_i);
   endtask

   // ----------------------------------------
   // monitor
   // ----------------------------------------

   // strobe history, valid is due two edges after the strobe
   always @(posedge hclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         strobe_d1 <= 1'b0;
         strobe_d2 <= 1'b0;
      end else begin
         strobe_d1 <= req_valid_i;
         strobe_d2 <= strobe_d1;
      end
   end

   task automatic check_field(input string name, input logic [31:0] got,
                              input logic [31:0] want);
      assert (got === want) else begin
         value_errs++;
         $display("error %s: got %08h expected %08h", name, got, want);
      end
   endtask

   // outputs only move on the rising edge, so sample on the falling one
   always @(negedge hclk_i) begin
      spu_pkg::spu_res_t want;
      assert (res_valid_o === strobe_d2) else begin
         timing_errs++;
         $display("error res_valid_o: got %0h expected %0h", res_valid_o, strobe_d2);
      end
      if (res_valid_o === 1'b1) begin
         assert (exp_q.size() != 0) else begin
            timing_errs++;
            $display("result valid with no request outstanding");
         end
         if (exp_q.size() != 0) begin
            want = exp_q.pop_front();
            check_field("res_o.res", res_o.res, want.res);
            check_field("res_o.nflag", 32'(res_o.nflag), 32'(want.nflag));
            check_field("res_o.zflag", 32'(res_o.zflag), 32'(want.zflag));
            check_field("res_o.cflag", 32'(res_o.cflag), 32'(want.cflag));
         end
      end
   end

   // ----------------------------------------
   // main sequence
   // ----------------------------------------

   task automatic finish_run();
      $display("summary: value errors %0d, timing errors %0d, timeouts %0d",
               value_errs, timing_errs, timeout_errs);
      if ((value_errs + timing_errs + timeout_errs) == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   endtask

   initial begin
      value_errs   = 0;
      timing_errs  = 0;
      timeout_errs = 0;
      arst_n_i     = 1'b0;
      req_valid_i  = 1'b0;
      req_i        = '0;
      build_table();
      // reset for two cycles, released away from the rising edge
      repeat (2) @(posedge hclk_i);
      @(negedge hclk_i);
      arst_n_i = 1'b1;
      run_tests();
      finish_run();
   end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
spu_pkg.sv
spu_amount_decode.sv
spu_rotator.sv
spu_lane_matrix.sv
spu.sv
tb_spu.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_spu
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# output is kept in a shell variable and searched for the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
